// File: filelist.f
+incdir+.
mem_pkg.sv
mem_bank.sv
mem_req_router.sv
mem_rsp_collect.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// File: mem_bank.sv
`timescale 1ns/10ps

module mem_bank (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::bank_req_t  breq,
    output mem_pkg::mem_word_u  rdata
);
    import mem_pkg::*;

    // storage and per-word written flags
    mem_word_u               mem [BANK_WORDS];
    logic [BANK_WORDS-1:0]   written;

    // current content of the addressed word as seen by a reader
    mem_word_u  cur_word;
    // word after merging the strobed lanes
    mem_word_u  merged;

    logic  wr_en;
    logic  rd_en;

    assign wr_en = breq.req && breq.we;
    assign rd_en = breq.req && !breq.we;

    // never-written words count as zero, also for a partial write
    always_comb begin
        if (written[breq.idx]) begin
            cur_word = mem[breq.idx];
        end else begin
            cur_word = '0;
        end
    end

    // byte lane merge
    always_comb begin
        merged = cur_word;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (breq.be[l]) begin
                merged.lanes[l] = breq.wdata.lanes[l];
            end
        end
    end

    // word array
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[breq.idx] <= merged;
        end
    end

    // written flags, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            written <= '0;
        end else if (wr_en) begin
            written[breq.idx] <= 1'b1;
        end
    end

    // registered read port
    // a write answers with zero so the collector can pass it straight on
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= cur_word;
        end else if (wr_en) begin
            rdata <= '0;
        end
    end

endmodule

// File: mem_pkg.sv
package mem_pkg;

    // word and address widths
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 32;
    localparam int LANE_W    = 8;
    localparam int NUM_LANES = DATA_W / LANE_W;

    // byte offset bits dropped from the wishbone address
    localparam int OFFS_W  = $clog2(NUM_LANES);
    localparam int WADDR_W = ADDR_W - OFFS_W;

    // bank layout
    localparam int NUM_BANKS  = 4;
    localparam int BANK_WORDS = 256;
    localparam int IDX_W      = 8;
    localparam int BANK_W     = 2;

    // first word address past the last bank
    localparam int MEM_WORDS = NUM_BANKS * BANK_WORDS;

    // one memory word, seen whole by the bus and per byte by the banks
    typedef union packed {
        logic [DATA_W-1:0]                 word;
        logic [NUM_LANES-1:0][LANE_W-1:0]  lanes;
    } mem_word_u;

    // wishbone classic, master side
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [NUM_LANES-1:0]  sel;
        logic [ADDR_W-1:0]     adr;
        mem_word_u             dat;
    } wb_req_t;

    // wishbone classic, slave side
    typedef struct packed {
        logic       ack;
        logic       err;
        mem_word_u  dat;
    } wb_rsp_t;

    // request into a single bank
    typedef struct packed {
        logic                  req;
        logic                  we;
        logic [NUM_LANES-1:0]  be;
        logic [IDX_W-1:0]      idx;
        mem_word_u             wdata;
    } bank_req_t;

    // accepted transaction, handed from router to collector
    typedef struct packed {
        logic               valid;
        logic [BANK_W-1:0]  bank;
        logic               err;
    } route_t;

endpackage

// File: mem_req_router.sv
`timescale 1ns/10ps

module mem_req_router (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::wb_req_t    wb_req,
    output mem_pkg::bank_req_t  breq [mem_pkg::NUM_BANKS],
    output mem_pkg::route_t     route
);
    import mem_pkg::*;

    // high in the cycle after a request was issued
    logic  busy;
    logic  accept;

    // address split
    logic [WADDR_W-1:0]  word_addr;
    logic [BANK_W-1:0]   bank_num;
    logic [IDX_W-1:0]    idx;
    logic                in_range;

    assign word_addr = wb_req.adr[ADDR_W-1:OFFS_W];
    assign bank_num  = word_addr[IDX_W +: BANK_W];
    assign idx       = word_addr[IDX_W-1:0];
    assign in_range  = (word_addr < WADDR_W'(MEM_WORDS));

    // new transaction seen on the bus and not yet served
    assign accept = wb_req.cyc && wb_req.stb && !busy;

    // one request per transaction
    // the master holds stb until it sees ack, so block the repeat
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else begin
            busy <= accept;
        end
    end

    // bank requests, only the addressed bank sees anything
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            breq[b] = '0;
            if (accept && in_range && (bank_num == BANK_W'(b))) begin
                breq[b].req   = 1'b1;
                breq[b].we    = wb_req.we;
                breq[b].be    = wb_req.sel;
                breq[b].idx   = idx;
                breq[b].wdata = wb_req.dat;
            end
        end
    end

    // tell the collector which bank answers, or that none will
    always_comb begin
        route.valid = accept;
        route.bank  = bank_num;
        route.err   = !in_range;
    end

endmodule

// File: mem_rsp_collect.sv
`timescale 1ns/10ps

module mem_rsp_collect (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::route_t     route,
    input  mem_pkg::mem_word_u  bank_rdata [mem_pkg::NUM_BANKS],
    output mem_pkg::wb_rsp_t    wb_rsp
);
    import mem_pkg::*;

    // route of the transaction being answered
    route_t     route_q;
    logic       ack;
    logic       err;
    mem_word_u  sel_data;

    // valid drops after one cycle since the router only pulses it
    always_ff @(posedge clk) begin
        if (rst) begin
            route_q <= '0;
        end else begin
            route_q <= route;
        end
    end

    assign ack = route_q.valid && !route_q.err;
    assign err = route_q.valid && route_q.err;

    // banks return zero for a write, so only err needs masking here
    always_comb begin
        if (ack) begin
            sel_data = bank_rdata[route_q.bank];
        end else begin
            sel_data = '0;
        end
    end

    always_comb begin
        wb_rsp.ack = ack;
        wb_rsp.err = err;
        wb_rsp.dat = sel_data;
    end

endmodule

// File: mem_subsys_top.sv
`timescale 1ns/10ps

module mem_subsys_top (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::wb_req_t  wb_req,
    output mem_pkg::wb_rsp_t  wb_rsp
);
    import mem_pkg::*;

    bank_req_t  breq       [NUM_BANKS];
    mem_word_u  bank_rdata [NUM_BANKS];
    route_t     route;

    // wishbone front end and address decode
    mem_req_router mem_req_router_inst (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .breq   (breq),
        .route  (route)
    );

    // identical banks
    for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
        mem_bank mem_bank_inst (
            .clk   (clk),
            .rst   (rst),
            .breq  (breq[i]),
            .rdata (bank_rdata[i])
        );
    end

    // response side
    mem_rsp_collect mem_rsp_collect_inst (
        .clk        (clk),
        .rst        (rst),
        .route      (route),
        .bank_rdata (bank_rdata),
        .wb_rsp     (wb_rsp)
    );

endmodule

// File: tb_mem_checks.svh
`ifndef TB_MEM_CHECKS_SVH
`define TB_MEM_CHECKS_SVH

    // stop the run at the first problem
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    // whole word compare of read data
    task automatic check_word(
        input mem_word_u  got,
        input mem_word_u  exp,
        input string      what
    );
        string  line;
        if (got.word !== exp.word) begin
            line = $sformatf("ERR at %0d ns: %s, got %08h expected %08h",
                             $time, what, got.word, exp.word);
            fail_run(line);
        end
    endtask

    // response kind by ack and err
    task automatic check_rsp(
        input wb_rsp_t  got,
        input wb_rsp_t  exp,
        input string    what
    );
        string  line;
        if ((got.ack !== exp.ack) || (got.err !== exp.err)) begin
            line = $sformatf("ERR at %0d ns: %s, got ack=%b err=%b expected ack=%b err=%b",
                             $time, what, got.ack, got.err, exp.ack, exp.err);
            fail_run(line);
        end
    endtask

    // nothing may be answered when no transaction is open
    task automatic check_quiet(input string what);
        wb_rsp_t  quiet;
        quiet = '0;
        check_rsp(wb_rsp, quiet, what);
    endtask

`endif

// File: tb_mem_subsys.sv
`timescale 1ns/10ps

module tb_mem_subsys;
    import mem_pkg::*;

    logic     clk;
    logic     rst;
    wb_req_t  wb_req;
    wb_rsp_t  wb_rsp;

    integer   seed;
    // reference memory keyed by word address, a missing key reads as zero
    logic [DATA_W-1:0]  model [int];
    int                 written_q [$];

    `include "tb_mem_checks.svh"

    mem_subsys_top mem_subsys_top_inst (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // step past the edge to where inputs change and outputs are settled
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset(input int n);
        rst = 1'b1;
        for (int i = 0; i < n; i++) begin
            next_cycle();
            check_quiet("response during reset");
        end
        rst = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            next_cycle();
            check_quiet("response while idle");
        end
    endtask

    function automatic logic [DATA_W-1:0] model_read(input int waddr);
        if (model.exists(waddr)) begin
            return model[waddr];
        end
        return '0;
    endfunction

    // byte lane merge of the strobed bytes
    function automatic void model_write(input int waddr, input logic [3:0] sel,
                                        input logic [DATA_W-1:0] wdat);
        logic [DATA_W-1:0]  w;
        w = model_read(waddr);
        for (int l = 0; l < 4; l++) begin
            if (sel[l]) begin
                w[8*l +: 8] = wdat[8*l +: 8];
            end
        end
        model[waddr] = w;
    endfunction

    function automatic int rand_in_range();
        return int'($unsigned($random(seed)) % MEM_WORDS);
    endfunction

    // anything from the first word past the banks up to the top of the bus
    function automatic int rand_out_range();
        logic [WADDR_W-1:0]  w;
        w = WADDR_W'($random(seed));
        if (w < MEM_WORDS) begin
            w = w | WADDR_W'(MEM_WORDS);
        end
        return int'(w);
    endfunction

    // one wishbone transaction checked against the model
    task automatic bus_xfer(input logic we, input logic [3:0] sel, input int waddr,
                            input logic [DATA_W-1:0] wdat, input logic hold_stb);
        wb_rsp_t    first;
        wb_rsp_t    got;
        wb_rsp_t    exp;
        mem_word_u  exp_dat;
        int         n;
        logic       in_range;

        in_range = (waddr >= 0) && (waddr < MEM_WORDS);
        exp = '0;
        exp.ack = in_range;
        exp.err = !in_range;
        // writes and errors come back with zero data
        exp_dat = '0;
        if (in_range && !we) begin
            exp_dat.word = model_read(waddr);
        end

        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = we;
        wb_req.sel = sel;
        wb_req.adr = ADDR_W'(waddr) << OFFS_W;
        wb_req.dat.word = wdat;

        n = 0;
        got = '0;
        first = '0;
        while (!(got.ack || got.err)) begin
            if (n == 20) begin
                fail_run("timeout: no ack or err within 20 cycles of a transaction");
            end
            next_cycle();
            n++;
            got = wb_rsp;
            if (n == 1) begin
                first = got;
            end
        end
        check_rsp(first, exp, $sformatf("response at second edge, word %0h", waddr));
        check_word(got.dat, exp_dat, $sformatf("data of word %0h", waddr));

        if (in_range && we) begin
            model_write(waddr, sel, wdat);
            written_q.push_back(waddr);
        end

        // master sees ack at this edge, response must be gone by now
        next_cycle();
        check_quiet("response held longer than one cycle");
        if (!hold_stb) begin
            wb_req.cyc = 1'b0;
            wb_req.stb = 1'b0;
        end
    endtask

    initial begin
        logic [31:0]  r;
        int           wa;
        int           idx;
        int           oor;

        seed = 32'hd712_26ee;
        rst = 1'b1;
        wb_req = '0;
        apply_reset(8);
        idle_cycles(4);

        // never written words
        for (int i = 0; i < 16; i++) begin
            bus_xfer(1'b0, 4'hf, rand_in_range(), '0, 1'b0);
        end

        // full word write then read, every bank
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int k = 0; k < 4; k++) begin
                wa = b * BANK_WORDS + int'($unsigned($random(seed)) % BANK_WORDS);
                bus_xfer(1'b1, 4'hf, wa, $random(seed), 1'b0);
                bus_xfer(1'b0, 4'hf, wa, '0, 1'b0);
            end
        end

        // partial writes over a known word
        for (int i = 0; i < 32; i++) begin
            wa = rand_in_range();
            bus_xfer(1'b1, 4'hf, wa, $random(seed), 1'b0);
            bus_xfer(1'b1, 4'($random(seed)), wa, $random(seed), 1'b0);
            bus_xfer(1'b0, 4'hf, wa, '0, 1'b0);
        end

        // out of range, same index must stay intact in every bank
        for (int i = 0; i < 8; i++) begin
            idx = int'($unsigned($random(seed)) % BANK_WORDS);
            for (int b = 0; b < NUM_BANKS; b++) begin
                bus_xfer(1'b1, 4'hf, b * BANK_WORDS + idx, $random(seed), 1'b0);
            end
            oor = (rand_out_range() & ~(BANK_WORDS - 1)) | idx;
            bus_xfer(1'b1, 4'hf, oor, $random(seed), 1'b0);
            bus_xfer(1'b0, 4'hf, oor, '0, 1'b0);
            for (int b = 0; b < NUM_BANKS; b++) begin
                bus_xfer(1'b0, 4'hf, b * BANK_WORDS + idx, '0, 1'b0);
            end
        end
        bus_xfer(1'b0, 4'hf, MEM_WORDS, '0, 1'b0);

        // second reset clears the written flags
        model.delete();
        apply_reset(8);
        idle_cycles(2);
        for (int i = 0; i < 16; i++) begin
            bus_xfer(1'b0, 4'hf, written_q[i], '0, 1'b0);
        end

        // random back to back traffic with stb kept high
        for (int t = 0; t < 400; t++) begin
            r = $random(seed);
            if (r[3:0] == 4'd0) begin
                wa = rand_out_range();
            end else if (r[4]) begin
                // small pool so reads often hit written words
                wa = int'(r[9:8]) * BANK_WORDS + int'(r[12:10]);
            end else begin
                wa = rand_in_range();
            end
            bus_xfer(r[5], r[19:16], wa, $random(seed), t != 399);
        end

        idle_cycles(4);
        $display("Testbench passed");
        $finish;
    end

endmodule
